//--- build.f
+incdir+hdl
hdl/cachePkg.sv
hdl/cacheWay.sv
hdl/lruTracker.sv
hdl/hitSelect.sv
hdl/cacheController.sv
hdl/m68kCache.sv
testbench/dramModel.sv
testbench/tbM68kCache.sv

//--- testbench/tbM68kCache.sv
// testbench for the 4-way 68k read cache in front of the burst dram model
// applies a table of reads and writes, predicted by a reference cache and shadow memory
`default_nettype none
`include "cache_params.svh"

module tbM68kCache import cachePkg::*; ();

	localparam int WAIT_LIMIT = 200;	// cycles per wait
	localparam int RANDOM_OPS = 40;
	localparam int MEM_WORDS = 4096;
	localparam int HIT_CYCLES = 2;	// request edge, then dtack in CheckHit
	localparam int GAP_SLOTS = 3;	// idle cycles between requests

	typedef struct packed {
		logic      isWrite;
		address_t  address;
		dataWord_t writeData;
		logic      expMiss;	// from the reference cache
		dataWord_t expData;	// from the shadow memory
	} stimEntry_t;

	logic      Clock;
	logic      Reset_L;
	cpuBus_t   cpu;
	dataWord_t cpuReadData;
	logic      dtackL;
	dramReq_t  dramReq;
	dataWord_t dramReadData;
	logic      dramDtackL;
	logic      casL;
	logic      rasL;

	stimEntry_t stimTable [$];
	tag_t       refTag [`CACHE_LINES][`CACHE_WAYS];
	logic       refValid [`CACHE_LINES][`CACHE_WAYS];
	lruBits_t   refLru [`CACHE_LINES];
	dataWord_t  shadowMem [MEM_WORDS];
	int         testsPassed;
	int         testsFailed;
	int         errorCount;	// failed checks in the running test
	logic       timedOut;
	logic [31:0] seed;

	m68kCache u_m68kCache (
		.Clock        (Clock),
		.Reset_L      (Reset_L),
		.cpu          (cpu),
		.cpuReadData  (cpuReadData),
		.dtackL       (dtackL),
		.dram         (dramReq),
		.dramReadData (dramReadData),
		.dramDtackL   (dramDtackL),
		.casL         (casL),
		.rasL         (rasL)
	);

	dramModel u_dramModel (
		.Clock    (Clock),
		.Reset_L  (Reset_L),
		.dram     (dramReq),
		.readData (dramReadData),
		.dtackL   (dramDtackL),
		.casL     (casL),
		.rasL     (rasL)
	);

	initial Clock = 1'b0;
	always #4 Clock = ~Clock;	// period 8

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic wayNum_t lruVictim(input lruBits_t bits);
		wayNum_t way;
		way[1] = bits[0];	// root picks the half
		way[0] = bits[0] ? bits[2] : bits[1];
		return way;
	endfunction

	// tree points away from the way just used
	function automatic lruBits_t lruTouched(input lruBits_t bits, input wayNum_t way);
		lruBits_t next;
		next = bits;
		next[0] = !way[1];
		if (way[1]) begin
			next[2] = !way[0];
		end else begin
			next[1] = !way[0];
		end
		return next;
	endfunction

	task automatic addEntry(input logic isWrite, input address_t address,
		input dataWord_t writeData);
		stimEntry_t entry;
		entry = '0;
		entry.isWrite = isWrite;
		entry.address = address;
		entry.writeData = writeData;
		stimTable.push_back(entry);
	endtask

	task automatic predictTable();
		stimEntry_t entry;
		lineIndex_t set;
		tag_t tag;
		logic found;
		wayNum_t way;
		for (int i = 0; i < stimTable.size(); i++) begin
			entry = stimTable[i];
			set = entry.address[6:4];
			tag = entry.address[31:7];
			found = 1'b0;
			way = '0;
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (refValid[set][w] && refTag[set][w] == tag) begin
					found = 1'b1;
					way = wayNum_t'(w);
				end
			end
			if (entry.isWrite) begin
				if (found) begin
					refValid[set][way] = 1'b0;	// write hit drops the line, lru untouched
				end
				shadowMem[entry.address[12:1]] = entry.writeData;
			end else begin
				if (!found) begin
					way = lruVictim(refLru[set]);
					refTag[set][way] = tag;
					refValid[set][way] = 1'b1;
				end
				refLru[set] = lruTouched(refLru[set], way);
				entry.expMiss = !found;
				entry.expData = shadowMem[entry.address[12:1]];
			end
			stimTable[i] = entry;
		end
	endtask

	////////////////////////////////////////
	// bus cycles
	////////////////////////////////////////
	task automatic driveSlot();
		@(posedge Clock);
		#1;
	endtask

	task automatic waitIdle();
		int n;
		n = 0;
		while (u_m68kCache.u_cacheController.state != Idle && n < WAIT_LIMIT) begin
			@(negedge Clock);
			n++;
		end
		if (u_m68kCache.u_cacheController.state != Idle) begin
			$display("timeout: controller never finished the invalidate walk");
			timedOut = 1'b1;
		end
	endtask

	task automatic readCycle(input stimEntry_t entry);
		int cycles;
		logic sawSelect;	// dram select seen means a miss
		cpu.address = entry.address;
		cpu.weL = 1'b1;
		cpu.udsL = 1'b0;
		cpu.ldsL = 1'b0;
		cpu.dramSelect = 1'b1;
		cpu.asL = 1'b0;
		cycles = 0;
		sawSelect = 1'b0;
		do begin
			@(negedge Clock);
			cycles++;
			if (!dramReq.selectL) begin
				sawSelect = 1'b1;
				if (dramReq.asL !== 1'b0) begin	// address strobe rides with the request
					$display("mismatch dram.asL exp %h got %h", 1'b0, dramReq.asL);
					errorCount++;
				end
			end
		end while (dtackL && cycles < WAIT_LIMIT);
		if (dtackL) begin
			$display("timeout: no dtackL on read of %h", entry.address);
			timedOut = 1'b1;
		end else begin
			if (sawSelect != entry.expMiss) begin
				$display("mismatch miss flag exp %h got %h", entry.expMiss, sawSelect);
				errorCount++;
			end
			if (cpuReadData != entry.expData) begin
				$display("mismatch cpuReadData exp %h got %h", entry.expData, cpuReadData);
				errorCount++;
			end
			if (!entry.expMiss && cycles != HIT_CYCLES) begin
				$display("mismatch dtackL latency exp %h got %h", HIT_CYCLES, cycles);
				errorCount++;
			end
		end
		driveSlot();
		cpu.asL = 1'b1;	// end of bus cycle
		cpu.dramSelect = 1'b0;
	endtask

	task automatic writeCycle(input stimEntry_t entry);
		int cycles;
		cpu.address = entry.address;
		cpu.writeData = entry.writeData;
		cpu.weL = 1'b0;
		cpu.udsL = 1'b0;
		cpu.ldsL = 1'b0;
		cpu.dramSelect = 1'b1;
		cpu.asL = 1'b0;
		cycles = 0;
		do begin
			@(negedge Clock);
			cycles++;
			if (dtackL !== dramDtackL) begin	// dtack is passed through
				$display("mismatch dtackL exp %h got %h", dramDtackL, dtackL);
				errorCount++;
			end
			if (!dramReq.selectL && dramReq.asL !== 1'b0) begin
				$display("mismatch dram.asL exp %h got %h", 1'b0, dramReq.asL);
				errorCount++;
			end
		end while (dtackL && cycles < WAIT_LIMIT);
		if (dtackL) begin
			$display("timeout: no dtackL on write of %h", entry.address);
			timedOut = 1'b1;
		end
		driveSlot();
		cpu.asL = 1'b1;
		cpu.dramSelect = 1'b0;
		cpu.weL = 1'b1;
		cpu.udsL = 1'b1;
		cpu.ldsL = 1'b1;
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial begin
		Reset_L = 1'b0;
		cpu = '{address: '0, writeData: '0, udsL: 1'b1, ldsL: 1'b1, weL: 1'b1,
			asL: 1'b1, dramSelect: 1'b0};
		testsPassed = 0;
		testsFailed = 0;
		errorCount = 0;
		timedOut = 1'b0;
		seed = 32'h877a;
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadowMem[i] = 16'(i) ^ 16'hA5C3;	// same fill as the dram model
		end
		for (int s = 0; s < `CACHE_LINES; s++) begin
			refLru[s] = '0;
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				refTag[s][w] = '0;
				refValid[s][w] = 1'b0;
			end
		end

		addEntry(1'b0, 32'h0000_0100, '0);	// cold miss
		addEntry(1'b0, 32'h0000_0106, '0);	// same line hit
		addEntry(1'b1, 32'h0000_0104, 16'h1234);
		addEntry(1'b0, 32'h0000_0104, '0);	// invalidated by the write
		// five tags on set 2, then reread them
		for (int t = 1; t <= 5; t++) begin
			addEntry(1'b0, (t << 7) | 32'h22, '0);
		end
		for (int t = 1; t <= 5; t++) begin
			addEntry(1'b0, (t << 7) | 32'h2C, '0);
		end
		for (int i = 0; i < RANDOM_OPS; i++) begin
			seed = xorshift(seed);
			addEntry(seed[31:30] == 2'b00, seed & 32'h0000_03FE, seed[27:12]);	// 1 KB window
		end
		predictTable();

		repeat (3) @(posedge Clock);
		#1 Reset_L = 1'b1;
		waitIdle();

		for (int i = 0; i < stimTable.size() && !timedOut; i++) begin
			repeat (GAP_SLOTS) driveSlot();
			errorCount = 0;
			if (stimTable[i].isWrite) begin
				writeCycle(stimTable[i]);
			end else begin
				readCycle(stimTable[i]);
			end
			if (errorCount != 0 || timedOut) begin
				testsFailed++;
				$display("test %0d %s %h failed", i, stimTable[i].isWrite ? "write" : "read",
					stimTable[i].address);
			end else begin
				testsPassed++;
				$display("test %0d %s %h ok", i, stimTable[i].isWrite ? "write" : "read",
					stimTable[i].address);
			end
		end

		$display("%0d tests, %0d passed, %0d failed", testsPassed + testsFailed,
			testsPassed, testsFailed);
		if (testsFailed == 0 && !timedOut) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/dramModel.sv
// behavioural burst dram controller for the cache testbench
// serves line reads with a refresh pulse then a cas strobe, and word writes with a delayed dtack
`default_nettype none
`include "cache_params.svh"

module dramModel import cachePkg::*; (
	input  wire logic     Clock,
	input  wire logic     Reset_L,
	input  wire dramReq_t dram,
	output dataWord_t     readData,
	output logic          dtackL,
	output logic          casL,
	output logic          rasL
);

	localparam int MEM_WORDS = 4096;	// address bits 12..1
	localparam int CAS_WAIT = 2;	// cycles from the refresh pulse to cas
	localparam int WRITE_WAIT = 2;	// cycles from select to dtack
	localparam int RELEASE_LIMIT = 200;

	dataWord_t mem [MEM_WORDS];

	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = 16'(i) ^ 16'hA5C3;	// every word differs
		end
		readData = '0;
		dtackL = 1'b1;
		casL = 1'b1;
		rasL = 1'b1;	// high outside the refresh pulse
	end

	// wait until the controller drops its select, bounded
	task automatic waitRelease();
		int n;
		n = 0;
		do begin
			@(negedge Clock);
			n++;
		end while (!dram.selectL && n < RELEASE_LIMIT);
	endtask

	////////////////////////////////////////
	// burst read, word k valid at edge 3+k after cas is seen
	////////////////////////////////////////
	task automatic burstRead(input logic [11:0] base);
		@(posedge Clock);
		#1 casL = 1'b0;	// cas with ras low is a refresh, not the read
		rasL = 1'b0;
		@(posedge Clock);
		#1 casL = 1'b1;
		rasL = 1'b1;
		repeat (CAS_WAIT - 1) @(posedge Clock);
		#1 casL = 1'b0;	// ras high so it reads as a cas cycle
		@(posedge Clock);	// controller detects cas here
		#1 casL = 1'b1;
		@(posedge Clock);
		for (int k = 0; k < `LINE_WORDS; k++) begin
			@(posedge Clock);
			#1 readData = mem[base + 12'(k)];
		end
		waitRelease();
	endtask

	task automatic writeStore(input logic [11:0] idx, input dataWord_t data,
		input logic upperL, input logic lowerL);
		if (!upperL) begin
			mem[idx][15:8] = data[15:8];
		end
		if (!lowerL) begin
			mem[idx][7:0] = data[7:0];
		end
		repeat (WRITE_WAIT) @(posedge Clock);
		#1 dtackL = 1'b0;
		waitRelease();	// held until select goes away
		@(posedge Clock);
		#1 dtackL = 1'b1;
	endtask

	always begin
		@(negedge Clock);	// request is stable here
		if (Reset_L && !dram.selectL) begin
			if (dram.weL) begin
				burstRead(dram.address[12:1]);	// word bits already cleared
			end else begin
				writeStore(dram.address[12:1], dram.writeData, dram.udsL, dram.ldsL);
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/m68kCache.sv
// 4-way read cache for a 68k-class cpu in front of a burst dram controller
// top level connecting the controller, the ways, hit select and lru
`default_nettype none
`include "cache_params.svh"

module m68kCache import cachePkg::*; (
	input  wire logic      Clock,
	input  wire logic      Reset_L,
	input  wire cpuBus_t   cpu,
	output dataWord_t      cpuReadData,
	output logic           dtackL,
	output dramReq_t       dram,
	input  wire dataWord_t dramReadData,
	input  wire logic      dramDtackL,
	input  wire logic      casL,	// watched to time the burst
	input  wire logic      rasL
);

	wayAccess_t access;	// common to every way
	wayMask_t tagWrite;
	wayMask_t dataWrite;
	wayMask_t validWrite;
	wayMask_t wayHit;
	dataWord_t [`CACHE_WAYS-1:0] wayData;
	logic hit;
	wayNum_t hitWay;
	wayNum_t victim;
	logic lruClear;
	logic lruTouch;
	wayNum_t lruWay;
	lineIndex_t lruIndex;

	////////////////////////////////////////
	// control
	////////////////////////////////////////
	cacheController u_cacheController (
		.Clock        (Clock),
		.Reset_L      (Reset_L),
		.cpu          (cpu),
		.hit          (hit),
		.hitWay       (hitWay),
		.wayHit       (wayHit),
		.victim       (victim),
		.casL         (casL),
		.rasL         (rasL),
		.dramDtackL   (dramDtackL),
		.dramReadData (dramReadData),
		.access       (access),
		.tagWrite     (tagWrite),
		.dataWrite    (dataWrite),
		.validWrite   (validWrite),
		.lruClear     (lruClear),
		.lruTouch     (lruTouch),
		.lruWay       (lruWay),
		.lruIndex     (lruIndex),
		.dram         (dram),
		.dtackL       (dtackL)
	);

	////////////////////////////////////////
	// storage
	////////////////////////////////////////
	for (genvar g = 0; g < `CACHE_WAYS; g++) begin : g_way
		cacheWay u_cacheWay (
			.Clock      (Clock),
			.Reset_L    (Reset_L),
			.access     (access),
			.tagWrite   (tagWrite[g]),
			.dataWrite  (dataWrite[g]),
			.validWrite (validWrite[g]),
			.hit        (wayHit[g]),
			.readData   (wayData[g])
		);
	end

	hitSelect u_hitSelect (
		.wayHit    (wayHit),
		.wayData   (wayData),
		.hit       (hit),
		.hitWay    (hitWay),
		.cacheData (cpuReadData)	// also valid in FillDone
	);

	lruTracker u_lruTracker (
		.Clock    (Clock),
		.Reset_L  (Reset_L),
		.index    (lruIndex),
		.clear    (lruClear),
		.touch    (lruTouch),
		.touchWay (lruWay),
		.victim   (victim)
	);

endmodule

`default_nettype wire

//--- hdl/cacheController.sv
// bus FSM of the cache between the 68k strobes and the burst dram controller
// drives the way enables, lru updates and the dram request
`default_nettype none
`include "cache_params.svh"

module cacheController import cachePkg::*; (
	input  wire logic      Clock,
	input  wire logic      Reset_L,
	input  wire cpuBus_t   cpu,
	input  wire logic      hit,
	input  wire wayNum_t   hitWay,
	input  wire wayMask_t  wayHit,
	input  wire wayNum_t   victim,	// from lru for the current index
	input  wire logic      casL,
	input  wire logic      rasL,
	input  wire logic      dramDtackL,
	input  wire dataWord_t dramReadData,
	output wayAccess_t     access,
	output wayMask_t       tagWrite,
	output wayMask_t       dataWrite,
	output wayMask_t       validWrite,
	output logic           lruClear,
	output logic           lruTouch,
	output wayNum_t        lruWay,
	output lineIndex_t     lruIndex,
	output dramReq_t       dram,
	output logic           dtackL
);

	// address field positions
	localparam int WORD_LSB = 1;
	localparam int INDEX_LSB = WORD_LSB + $clog2(`LINE_WORDS);
	localparam int TAG_LSB = INDEX_LSB + $clog2(`CACHE_LINES);
	// counter covers both the invalidate walk and the burst
	localparam int COUNT_WIDTH = ($clog2(`LINE_WORDS) > $clog2(`CACHE_LINES)) ?
		$clog2(`LINE_WORDS) : $clog2(`CACHE_LINES);

	cacheState_e state;
	cacheState_e nextState;
	logic [COUNT_WIDTH-1:0] burstCount;	// burst beat or set being invalidated
	logic countClear;
	logic countStep;
	wayNum_t victimReg;	// way being refilled
	logic victimLoad;
	wayMask_t victimMask;
	address_t lineAddr;	// line base for the burst read
	logic readReq;
	logic writeReq;

	assign readReq = !cpu.asL && cpu.dramSelect && cpu.weL;
	assign writeReq = !cpu.asL && cpu.dramSelect && !cpu.weL;
	assign victimMask = wayMask_t'(1) << victimReg;
	assign lineAddr = cpu.address & ~address_t'(2 ** INDEX_LSB - 1);	// word bits cleared
	assign lruIndex = access.index;

	////////////////////////////////////////
	// registers
	////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= Reset;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			burstCount <= '0;
		end else if (countClear) begin
			burstCount <= '0;
		end else if (countStep) begin
			burstCount <= burstCount + 1'b1;	// wraps after the last set or word
		end
	end

	always_ff @(posedge Clock) begin
		if (victimLoad) begin
			victimReg <= victim;
		end
	end

	////////////////////////////////////////
	// next state and outputs
	////////////////////////////////////////
	always_comb begin
		nextState = state;
		access.index = cpu.address[INDEX_LSB +: $bits(lineIndex_t)];
		access.word = cpu.address[WORD_LSB +: $bits(wordSel_t)];
		access.tag = cpu.address[TAG_LSB +: $bits(tag_t)];
		access.fillData = dramReadData;
		access.validIn = 1'b0;
		tagWrite = '0;
		dataWrite = '0;
		validWrite = '0;
		lruClear = 1'b0;
		lruTouch = 1'b0;
		lruWay = hitWay;
		dram.address = lineAddr;	// reads fetch the whole line
		dram.writeData = cpu.writeData;
		dram.udsL = 1'b0;	// reads take both bytes
		dram.ldsL = 1'b0;
		dram.weL = cpu.weL;
		dram.asL = cpu.asL;
		dram.selectL = 1'b1;
		dtackL = 1'b1;
		countClear = 1'b0;
		countStep = 1'b0;
		victimLoad = 1'b0;

		case (state)
			Reset: begin
				countClear = 1'b1;
				nextState = Invalidate;
			end
			Invalidate: begin
				access.index = lineIndex_t'(burstCount);	// one set per cycle
				validWrite = '1;
				lruClear = 1'b1;
				countStep = 1'b1;
				if (burstCount == COUNT_WIDTH'(`CACHE_LINES - 1)) begin
					nextState = Idle;
				end
			end
			Idle: begin
				if (readReq) begin
					nextState = CheckHit;
				end else if (writeReq) begin
					dram.address = cpu.address;	// write goes straight through
					dram.udsL = cpu.udsL;
					dram.ldsL = cpu.ldsL;
					dram.selectL = 1'b0;
					validWrite = wayHit;	// no allocate, drop a stale copy
					nextState = WriteThrough;
				end
			end
			CheckHit: begin
				lruTouch = 1'b1;
				if (hit) begin
					dtackL = 1'b0;	// cache word is on cpuReadData now
					nextState = HitHold;
				end else begin
					victimLoad = 1'b1;
					lruWay = victim;	// refilled way becomes most recent
					dram.selectL = 1'b0;
					nextState = MissWait;
				end
			end
			HitHold: begin
				dtackL = 1'b0;
				if (cpu.asL) begin
					nextState = Idle;
				end
			end
			MissWait: begin
				dram.selectL = 1'b0;
				tagWrite = victimMask;
				validWrite = victimMask;
				access.validIn = 1'b1;
				if (!casL && rasL) begin	// read cas, not a refresh
					nextState = CasDelay1;
				end
			end
			CasDelay1: begin
				dram.selectL = 1'b0;
				countClear = 1'b1;
				nextState = CasDelay2;
			end
			CasDelay2: begin
				dram.selectL = 1'b0;
				if (burstCount == COUNT_WIDTH'(`FILL_LAT - 2)) begin
					countClear = 1'b1;
					nextState = BurstFill;
				end else begin
					countStep = 1'b1;	// extra latency beyond two
				end
			end
			BurstFill: begin
				dram.selectL = 1'b0;
				access.word = wordSel_t'(burstCount);
				dataWrite = victimMask;
				countStep = 1'b1;
				if (burstCount == COUNT_WIDTH'(`LINE_WORDS - 1)) begin
					nextState = FillDone;
				end
			end
			FillDone: begin
				dtackL = 1'b0;	// victim way now hits on the cpu word
				if (cpu.asL || !cpu.dramSelect) begin
					nextState = Idle;
				end
			end
			WriteThrough: begin
				dram.address = cpu.address;
				dram.udsL = cpu.udsL;
				dram.ldsL = cpu.ldsL;
				dram.selectL = 1'b0;
				dtackL = dramDtackL;	// dram sets the write latency
				if (cpu.asL) begin
					nextState = Idle;
				end
			end
			default: begin
				nextState = Reset;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/hitSelect.sv
// turns the per-way hit flags into one hit, its way number and its data word
// after a fill the refilled way hits so cacheData also serves FillDone
`default_nettype none
`include "cache_params.svh"

module hitSelect import cachePkg::*; (
	input  wire wayMask_t                   wayHit,
	input  wire dataWord_t [`CACHE_WAYS-1:0] wayData,
	output logic                            hit,
	output wayNum_t                         hitWay,
	output dataWord_t                       cacheData
);

	// at most one way hits so a plain scan encodes it
	always_comb begin
		hitWay = '0;
		for (int i = 0; i < `CACHE_WAYS; i++) begin
			if (wayHit[i]) begin
				hitWay = wayNum_t'(i);
			end
		end
	end

	assign hit = |wayHit;
	assign cacheData = wayData[hitWay];	// way 0 word when nothing hits

endmodule

`default_nettype wire

//--- hdl/lruTracker.sv
// tree pseudo-LRU record per set
// gives the victim way for the current index and updates on touch or clear
`default_nettype none
`include "cache_params.svh"

module lruTracker import cachePkg::*; (
	input  wire logic       Clock,
	input  wire logic       Reset_L,
	input  wire lineIndex_t index,
	input  wire logic       clear,	// zero the record at index
	input  wire logic       touch,	// mark touchWay most recent
	input  wire wayNum_t    touchWay,
	output wayNum_t         victim
);

	lruBits_t lruMem [`CACHE_LINES];
	lruBits_t current;	// record of the addressed set
	lruBits_t updated;

	assign current = lruMem[index];

	////////////////////////////////////////
	// victim from the tree bits
	////////////////////////////////////////
	always_comb begin
		if (!current[0]) begin
			victim = current[1] ? 2'd1 : 2'd0;	// left half
		end else begin
			victim = current[2] ? 2'd3 : 2'd2;	// right half
		end
	end

	// point the tree away from the touched way
	always_comb begin
		updated = current;
		case (touchWay)
			2'd0: begin
				updated[0] = 1'b1;
				updated[1] = 1'b1;
			end
			2'd1: begin
				updated[0] = 1'b1;
				updated[1] = 1'b0;
			end
			2'd2: begin
				updated[0] = 1'b0;
				updated[2] = 1'b1;
			end
			default: begin
				updated[0] = 1'b0;
				updated[2] = 1'b0;
			end
		endcase
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			for (int i = 0; i < `CACHE_LINES; i++) begin
				lruMem[i] <= '0;
			end
		end else if (clear) begin
			lruMem[index] <= '0;	// invalidate walk
		end else if (touch) begin
			lruMem[index] <= updated;
		end
	end

endmodule

`default_nettype wire

//--- hdl/cacheWay.sv
// one way of the cache with tag, valid bit and line data per set
// the tag compare runs every cycle against access.tag at access.index
`default_nettype none
`include "cache_params.svh"

module cacheWay import cachePkg::*; (
	input  wire logic       Clock,
	input  wire logic       Reset_L,
	input  wire wayAccess_t access,	// index, word and write data from controller
	input  wire logic       tagWrite,
	input  wire logic       dataWrite,
	input  wire logic       validWrite,
	output logic            hit,
	output dataWord_t       readData
);

	tag_t      tagMem [`CACHE_LINES];		// one tag per set
	dataWord_t dataMem [`CACHE_LINES][`LINE_WORDS];	// line words
	logic [`CACHE_LINES-1:0] validBits;

	////////////////////////////////////////
	// tag and data storage
	////////////////////////////////////////
	always_ff @(posedge Clock) begin
		if (tagWrite) begin
			tagMem[access.index] <= access.tag;	// written while the miss waits for cas
		end
		if (dataWrite) begin
			dataMem[access.index][access.word] <= access.fillData;	// one word per burst beat
		end
	end

	// valid bits
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			validBits <= '0;
		end else if (validWrite) begin
			validBits[access.index] <= access.validIn;
		end
	end

	////////////////////////////////////////
	// lookup
	////////////////////////////////////////
	assign hit = validBits[access.index] && (tagMem[access.index] == access.tag);
	assign readData = dataMem[access.index][access.word];	// word is the cpu word outside a fill

endmodule

`default_nettype wire

//--- hdl/cachePkg.sv
// types shared by the cache blocks
// modules pull these in with a wildcard import in their header
`default_nettype none
`include "cache_params.svh"

package cachePkg;

	////////////////////////////////////////
	// plain vectors
	////////////////////////////////////////
	typedef logic [`ADDR_WIDTH-1:0]           address_t;	// cpu byte address
	typedef logic [`DATA_WIDTH-1:0]           dataWord_t;
	typedef logic [`TAG_WIDTH-1:0]            tag_t;	// address bits 31..7
	typedef logic [$clog2(`CACHE_LINES)-1:0]  lineIndex_t;	// address bits 6..4
	typedef logic [$clog2(`LINE_WORDS)-1:0]   wordSel_t;	// address bits 3..1
	typedef logic [$clog2(`CACHE_WAYS)-1:0]   wayNum_t;
	typedef logic [`CACHE_WAYS-1:0]           wayMask_t;	// one bit per way
	typedef logic [2:0]                       lruBits_t;	// bit 0 root, 1 ways 0/1, 2 ways 2/3

	// controller states
	typedef enum logic [3:0] {
		Reset,
		Invalidate,	// walk every set clearing valid and lru
		Idle,
		CheckHit,
		HitHold,	// hold dtack until the cpu ends the cycle
		MissWait,	// wait for the dram to start its cas
		CasDelay1,
		CasDelay2,
		BurstFill,
		FillDone,
		WriteThrough
	} cacheState_e;

	////////////////////////////////////////
	// bundles
	////////////////////////////////////////
	typedef struct packed {
		address_t  address;
		dataWord_t writeData;
		logic      udsL;	// upper byte strobe
		logic      ldsL;	// lower byte strobe
		logic      weL;
		logic      asL;
		logic      dramSelect;	// active high, dram range decoded
	} cpuBus_t;

	typedef struct packed {
		address_t  address;
		dataWord_t writeData;
		logic      udsL;
		logic      ldsL;
		logic      weL;
		logic      asL;
		logic      selectL;
	} dramReq_t;

	// driven in common to all ways
	typedef struct packed {
		lineIndex_t index;
		wordSel_t   word;
		tag_t       tag;
		dataWord_t  fillData;
		logic       validIn;
	} wayAccess_t;

endpackage

`default_nettype wire

//--- hdl/cache_params.svh
// cache geometry and bus widths shared by the package and every RTL block
// include this before any use of the macros below
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

////////////////////////////////////////
// cache geometry
////////////////////////////////////////
`define CACHE_WAYS	4	// ways per set
`define CACHE_LINES	8	// sets, indexed by address bits 6..4
`define LINE_WORDS	8	// 16-bit words per line

////////////////////////////////////////
// bus widths
////////////////////////////////////////
`define ADDR_WIDTH	32	// 68k address bus
`define DATA_WIDTH	16	// 68k and dram data bus
`define TAG_WIDTH	25	// address bits 31..7

// dram timing
// first burst word arrives this many cycles after cas low is seen
`define FILL_LAT	2

`endif
